/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// Master and slave buses both move one byte per transfer
	localparam int data_width = 8;

	// Target address carried with every master frame
	typedef logic [7:0] bus_addr_t;

	// Nodes sharing the slave bus
	localparam int node_count = 2;

endpackage

`default_nettype wire

/* design/msg_pkg.sv */
`default_nettype none

package msg_pkg;

	// Length byte sent ahead of each reply, payload bytes only
	typedef logic [7:0] frame_len_t;

	// Longest legal payload
	localparam int max_frame_bytes = 16;

	// Byte depths of the node FIFOs
	localparam int in_fifo_depth = 8;
	localparam int out_fifo_depth = 32;

endpackage

`default_nettype wire

/* design/message_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module message_fifo import bus_pkg::*, msg_pkg::*; #(
	parameter int DEPTH = 8
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [data_width-1:0] in_data,
	input  logic                  in_data_latch,
	input  logic                  in_frame_valid,
	output logic                  in_data_overflow,
	input  logic                  populate_frame_length,
	output logic [data_width-1:0] out_data,
	output logic                  out_frame_valid,
	input  logic                  out_data_latch
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [data_width-1:0] mem [DEPTH];
	// Every committed frame holds at least one byte, so DEPTH entries suffice
	frame_len_t len_q [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] frame_start;
	logic [AW-1:0] len_wr;
	logic [AW-1:0] len_rd;
	logic [CW-1:0] used;
	logic [CW-1:0] len_cnt;
	frame_len_t    cur_len;
	frame_len_t    rd_cnt;
	frame_len_t    head_len;
	logic          in_frame_q;
	logic          hdr_done;
	logic          gap;

	logic new_frame;
	logic frame_end;
	logic wr_req;
	logic discard;
	logic wr_ok;
	logic commit;
	logic pop;
	logic pop_hdr;
	logic pop_byte;
	logic pop_last;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign new_frame = in_frame_valid && !in_frame_q;
	assign frame_end = !in_frame_valid && in_frame_q;

	// Bytes of an overflowed frame are dropped until a new frame opens
	assign wr_req  = in_data_latch && in_frame_valid && (!in_data_overflow || new_frame);
	assign discard = wr_req && (used == CW'(DEPTH) || cur_len == frame_len_t'(max_frame_bytes));
	assign wr_ok   = wr_req && !discard;
	assign commit  = frame_end && !in_data_overflow && cur_len != '0;

	// Read side, one frame at a time
	assign head_len        = len_q[len_rd];
	assign out_frame_valid = (len_cnt != '0) && !gap;
	assign pop             = out_data_latch && out_frame_valid;
	assign pop_hdr         = pop && populate_frame_length && !hdr_done;
	assign pop_byte        = pop && !pop_hdr;
	assign pop_last        = pop_byte && (rd_cnt + 1'b1 == head_len);
	assign out_data        = (populate_frame_length && !hdr_done) ? head_len : mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= in_data;
		end
		if (commit) begin
			len_q[len_wr] <= cur_len;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr           <= '0;
			rd_ptr           <= '0;
			frame_start      <= '0;
			len_wr           <= '0;
			len_rd           <= '0;
			used             <= '0;
			len_cnt          <= '0;
			cur_len          <= '0;
			rd_cnt           <= '0;
			in_frame_q       <= 1'b0;
			hdr_done         <= 1'b0;
			gap              <= 1'b0;
			in_data_overflow <= 1'b0;
		end else begin
			in_frame_q <= in_frame_valid;
			// Forces out_frame_valid low for a cycle between frames
			gap        <= pop_last;
			used       <= used + CW'(wr_ok) - CW'(pop_byte) - (discard ? CW'(cur_len) : CW'(0));
			len_cnt    <= len_cnt + CW'(commit) - CW'(pop_last);

			if (new_frame) begin
				in_data_overflow <= 1'b0;
			end
			if (discard) begin
				// Roll back to where the broken frame began
				in_data_overflow <= 1'b1;
				wr_ptr           <= frame_start;
				cur_len          <= '0;
			end else if (wr_ok) begin
				wr_ptr  <= ptr_inc(wr_ptr);
				cur_len <= cur_len + 1'b1;
			end

			if (commit) begin
				len_wr      <= ptr_inc(len_wr);
				frame_start <= wr_ptr;
				cur_len     <= '0;
			end

			if (pop_hdr) begin
				hdr_done <= 1'b1;
			end
			if (pop_byte) begin
				rd_ptr <= ptr_inc(rd_ptr);
				rd_cnt <= rd_cnt + 1'b1;
			end
			if (pop_last) begin
				len_rd   <= ptr_inc(len_rd);
				rd_cnt   <= '0;
				hdr_done <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/bus_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_interface import bus_pkg::*, msg_pkg::*; #(
	parameter bus_addr_t ADDR                = '0,
	parameter bit        INCLUDE_INPUT_FIFO  = 1'b0,
	parameter bit        INCLUDE_OUTPUT_FIFO = 1'b0,
	parameter int        IN_FIFO_DEPTH       = in_fifo_depth,
	parameter int        OUT_FIFO_DEPTH      = out_fifo_depth
) (
	input  logic                  clk,
	input  logic                  rst,

	// Master bus
	input  logic [data_width-1:0] ma_data,
	input  bus_addr_t             ma_addr,
	input  logic                  ma_data_valid,
	input  logic                  ma_frame_valid,
	inout  wire                   sl_overflow,

	// Slave bus
	inout  wire  [data_width-1:0] sl_data,
	output logic                  sl_arb_request,
	input  logic                  sl_arb_grant,
	input  logic                  sl_data_latch,

	// Local input side
	output logic [data_width-1:0] in_frame_data,
	output logic                  in_frame_data_valid,
	output logic                  in_frame_valid,
	input  logic                  in_frame_data_latch,

	// Local output side
	input  logic [data_width-1:0] out_frame_data,
	input  logic                  out_frame_valid,
	input  logic                  out_frame_data_latch
);
	logic addr_match;

	assign addr_match = (ma_addr == ADDR);

	generate
		if (INCLUDE_INPUT_FIFO) begin : gen_in_fifo
			logic in_ovf;

			message_fifo #(
				.DEPTH(IN_FIFO_DEPTH)
			) u_in_fifo (
				.clk                  (clk),
				.rst                  (rst),
				.in_data              (ma_data),
				.in_data_latch        (ma_data_valid && addr_match),
				.in_frame_valid       (ma_frame_valid && addr_match),
				.in_data_overflow     (in_ovf),
				.populate_frame_length(1'b0),
				.out_data             (in_frame_data),
				.out_frame_valid      (in_frame_valid),
				.out_data_latch       (in_frame_data_latch)
			);

			// Stored frame bytes are always ready to pop
			assign in_frame_data_valid = 1'b1;
			assign sl_overflow         = addr_match ? in_ovf : 1'bz;
		end else begin : gen_in_stream
			assign in_frame_data       = ma_data;
			assign in_frame_data_valid = ma_data_valid && addr_match;
			assign in_frame_valid      = ma_frame_valid && addr_match;
			assign sl_overflow         = addr_match ? 1'b0 : 1'bz;
		end
	endgenerate

	generate
		if (INCLUDE_OUTPUT_FIFO) begin : gen_out_fifo
			logic [data_width-1:0] local_sl_data;

			// The echo path has no back-pressure, so overflow is left open
			message_fifo #(
				.DEPTH(OUT_FIFO_DEPTH)
			) u_out_fifo (
				.clk                  (clk),
				.rst                  (rst),
				.in_data              (out_frame_data),
				.in_data_latch        (out_frame_data_latch),
				.in_frame_valid       (out_frame_valid),
				.in_data_overflow     (),
				.populate_frame_length(1'b1),
				.out_data             (local_sl_data),
				.out_frame_valid      (sl_arb_request),
				.out_data_latch       (sl_data_latch)
			);

			assign sl_data = sl_arb_grant ? local_sl_data : 'z;
		end else begin : gen_out_none
			assign sl_data        = sl_arb_grant ? '0 : 'z;
			assign sl_arb_request = 1'b0;
		end
	endgenerate

endmodule

`default_nettype wire

/* design/frame_echo.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_echo import bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [data_width-1:0] in_frame_data,
	input  logic                  in_frame_data_valid,
	input  logic                  in_frame_valid,
	output logic                  in_frame_data_latch,
	output logic [data_width-1:0] out_frame_data,
	output logic                  out_frame_data_latch,
	output logic                  out_frame_valid
);
	logic take;

	// With a FIFO behind it this pops every cycle of a stored frame,
	// with a raw stream it follows the master data strobe
	assign take                = in_frame_valid && in_frame_data_valid;
	assign in_frame_data_latch = take;

	always_ff @(posedge clk) begin
		if (take) begin
			out_frame_data <= in_frame_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_frame_data_latch <= 1'b0;
			out_frame_valid      <= 1'b0;
		end else begin
			out_frame_data_latch <= take;
			// Reply frame lags the input frame by one cycle
			out_frame_valid      <= in_frame_valid;
		end
	end

endmodule

`default_nettype wire

/* design/slave_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module slave_arbiter import bus_pkg::*, msg_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [node_count-1:0] sl_arb_request,
	output logic [node_count-1:0] sl_arb_grant,
	output logic [node_count-1:0] sl_data_latch,
	input  logic [data_width-1:0] sl_data,
	output logic [data_width-1:0] slave_data,
	output logic                  slave_valid,
	output logic                  slave_last,
	input  logic                  slave_ready
);
	localparam int IW = (node_count > 1) ? $clog2(node_count) : 1;

	logic          busy;
	logic          hdr_phase;
	logic [IW-1:0] cur_idx;
	logic [IW-1:0] pick_idx;
	logic          pick_valid;
	frame_len_t    fetch_left;
	logic          take;
	logic          load;

	// Round robin, searching from the node after the last one served
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_idx   = cur_idx;
		for (int i = node_count; i >= 1; i--) begin
			idx = int'(cur_idx) + i;
			if (idx >= node_count) begin
				idx = idx - node_count;
			end
			if (sl_arb_request[idx]) begin
				pick_valid = 1'b1;
				pick_idx   = IW'(idx);
			end
		end
	end

	always_comb begin
		sl_arb_grant = '0;
		if (busy) begin
			sl_arb_grant[cur_idx] = 1'b1;
		end
	end

	assign take          = slave_valid && slave_ready;
	// Pull the next byte only when the output register frees up
	assign load          = busy && (hdr_phase || fetch_left != '0) && (!slave_valid || slave_ready);
	assign sl_data_latch = load ? sl_arb_grant : '0;

	always_ff @(posedge clk) begin
		if (load) begin
			slave_data <= sl_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy        <= 1'b0;
			hdr_phase   <= 1'b0;
			cur_idx     <= IW'(node_count - 1);
			fetch_left  <= '0;
			slave_valid <= 1'b0;
			slave_last  <= 1'b0;
		end else begin
			if (load) begin
				slave_valid <= 1'b1;
				if (hdr_phase) begin
					// First byte is the payload count
					hdr_phase  <= 1'b0;
					fetch_left <= frame_len_t'(sl_data);
					slave_last <= (sl_data == '0);
				end else begin
					fetch_left <= fetch_left - 1'b1;
					slave_last <= (fetch_left == frame_len_t'(1));
				end
			end else if (take) begin
				slave_valid <= 1'b0;
				slave_last  <= 1'b0;
			end

			if (busy && take && slave_last) begin
				busy <= 1'b0;
			end
			if (!busy && pick_valid) begin
				busy      <= 1'b1;
				cur_idx   <= pick_idx;
				hdr_phase <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/message_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module message_bus_top import bus_pkg::*, msg_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  bus_addr_t             ma_addr,
	input  logic [data_width-1:0] ma_data,
	input  logic                  ma_data_valid,
	input  logic                  ma_frame_valid,
	output logic                  ma_overflow,
	output logic [data_width-1:0] slave_data,
	output logic                  slave_valid,
	output logic                  slave_last,
	input  logic                  slave_ready
);
	// Node 0 buffers its input, node 1 streams
	localparam bus_addr_t node_addr [node_count]    = '{8'h10, 8'h20};
	localparam bit        node_in_fifo [node_count] = '{1'b1, 1'b0};

	tri  [data_width-1:0] sl_data;
	// Reads low when no node claims the address
	tri0                  sl_overflow;
	wire [node_count-1:0] sl_arb_request;
	wire [node_count-1:0] sl_arb_grant;
	wire [node_count-1:0] sl_data_latch;

	assign ma_overflow = sl_overflow;

	generate
		for (genvar n = 0; n < node_count; n++) begin : gen_node
			logic [data_width-1:0] in_frame_data;
			logic                  in_frame_data_valid;
			logic                  in_frame_valid;
			logic                  in_frame_data_latch;
			logic [data_width-1:0] out_frame_data;
			logic                  out_frame_data_latch;
			logic                  out_frame_valid;

			bus_interface #(
				.ADDR               (node_addr[n]),
				.INCLUDE_INPUT_FIFO (node_in_fifo[n]),
				.INCLUDE_OUTPUT_FIFO(1'b1),
				.IN_FIFO_DEPTH      (in_fifo_depth),
				.OUT_FIFO_DEPTH     (out_fifo_depth)
			) u_bus_if (
				.clk                 (clk),
				.rst                 (rst),
				.ma_data             (ma_data),
				.ma_addr             (ma_addr),
				.ma_data_valid       (ma_data_valid),
				.ma_frame_valid      (ma_frame_valid),
				.sl_overflow         (sl_overflow),
				.sl_data             (sl_data),
				.sl_arb_request      (sl_arb_request[n]),
				.sl_arb_grant        (sl_arb_grant[n]),
				.sl_data_latch       (sl_data_latch[n]),
				.in_frame_data       (in_frame_data),
				.in_frame_data_valid (in_frame_data_valid),
				.in_frame_valid      (in_frame_valid),
				.in_frame_data_latch (in_frame_data_latch),
				.out_frame_data      (out_frame_data),
				.out_frame_valid     (out_frame_valid),
				.out_frame_data_latch(out_frame_data_latch)
			);

			frame_echo u_echo (
				.clk                 (clk),
				.rst                 (rst),
				.in_frame_data       (in_frame_data),
				.in_frame_data_valid (in_frame_data_valid),
				.in_frame_valid      (in_frame_valid),
				.in_frame_data_latch (in_frame_data_latch),
				.out_frame_data      (out_frame_data),
				.out_frame_data_latch(out_frame_data_latch),
				.out_frame_valid     (out_frame_valid)
			);
		end
	endgenerate

	slave_arbiter u_arbiter (
		.clk           (clk),
		.rst           (rst),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant  (sl_arb_grant),
		.sl_data_latch (sl_data_latch),
		.sl_data       (sl_data),
		.slave_data    (slave_data),
		.slave_valid   (slave_valid),
		.slave_last    (slave_last),
		.slave_ready   (slave_ready)
	);

endmodule

`default_nettype wire

/* verif/bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_checker import bus_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input logic                  ma_frame_valid,
	input logic                  ma_overflow,
	input logic [data_width-1:0] slave_data,
	input logic                  slave_valid,
	input logic                  slave_last,
	input logic                  slave_ready
);
	logic [data_width-1:0] exp_data [$];
	bit                    exp_last [$];
	bit                    exp_ovf [$];
	logic [data_width-1:0] want_data;
	bit                    want_last;
	bit                    want_ovf;
	int                    n_tests = 0;
	int                    n_errors = 0;
	int                    reply_num = 1;
	int                    byte_num = 0;
	int                    frame_num = 1;
	bit                    reply_bad = 1'b0;
	bit                    frame_prev = 1'b0;
	bit                    ovf_seen = 1'b0;

	task automatic expect_byte(input logic [data_width-1:0] b, input bit last);
		exp_data.push_back(b);
		exp_last.push_back(last);
	endtask

	task automatic expect_frame(input bit ovf);
		exp_ovf.push_back(ovf);
	endtask

	function automatic bit all_seen();
		return exp_data.size() == 0 && exp_ovf.size() == 0;
	endfunction

	task automatic report();
		$display("Summary: %0d tests, %0d errors", n_tests, n_errors);
	endtask

	// Reply bytes, compared in order as they transfer
	always @(posedge clk) begin
		if (!rst && slave_valid && slave_ready) begin
			if (exp_data.size() == 0) begin
				$display("Reply byte 0x%02h arrived when no reply was expected", slave_data);
				n_errors++;
			end else begin
				want_data = exp_data.pop_front();
				want_last = exp_last.pop_front();
				if (slave_data !== want_data) begin
					$display("Fail slave_data: reply %0d byte %0d expected 0x%02h got 0x%02h",
						reply_num, byte_num, want_data, slave_data);
					reply_bad = 1'b1;
					n_errors++;
				end
				if (slave_last !== want_last) begin
					$display("Fail slave_last: reply %0d byte %0d expected 0x%0h got 0x%0h",
						reply_num, byte_num, want_last, slave_last);
					reply_bad = 1'b1;
					n_errors++;
				end
				byte_num++;
				if (want_last) begin
					n_tests++;
					$display("Reply %0d: %s", reply_num, reply_bad ? "failed" : "ok");
					reply_num++;
					byte_num  = 0;
					reply_bad = 1'b0;
				end
			end
		end
	end

	// Overflow window skips a frame's first cycle, where a stale flag may show
	always @(posedge clk) begin
		if (!rst) begin
			if (frame_prev && ma_overflow === 1'b1) begin
				ovf_seen = 1'b1;
			end
			if (frame_prev && !ma_frame_valid) begin
				if (exp_ovf.size() == 0) begin
					$display("Master frame %0d closed but the trace lists no such frame", frame_num);
					n_errors++;
				end else begin
					want_ovf = exp_ovf.pop_front();
					n_tests++;
					if (ovf_seen != want_ovf) begin
						$display("Fail ma_overflow: frame %0d expected 0x%0h got 0x%0h",
							frame_num, want_ovf, ovf_seen);
						n_errors++;
						$display("Frame %0d overflow: failed", frame_num);
					end else begin
						$display("Frame %0d overflow: ok", frame_num);
					end
				end
				frame_num++;
				ovf_seen = 1'b0;
			end
			frame_prev = ma_frame_valid;
		end
	end

endmodule

`default_nettype wire

/* verif/tb_message_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_message_bus
	import bus_pkg::*;
();
	logic                  clk;
	logic                  rst;
	bus_addr_t             ma_addr;
	logic [data_width-1:0] ma_data;
	logic                  ma_data_valid;
	logic                  ma_frame_valid;
	logic                  ma_overflow;
	logic [data_width-1:0] slave_data;
	logic                  slave_valid;
	logic                  slave_last;
	logic                  slave_ready;
	integer                seed;

	// Trace operations in file order, S frames and G gaps
	logic [7:0]            op_kind [$];
	bus_addr_t             op_addr [$];
	int                    op_len [$];
	int                    op_first [$];
	logic [data_width-1:0] byte_pool [$];
	bit                    frame_ovf [$];
	int                    n_lines = 0;
	bit                    trace_ok = 1'b0;
	bit                    trace_ready = 1'b0;

	message_bus_top UUT (
		.clk           (clk),
		.rst           (rst),
		.ma_addr       (ma_addr),
		.ma_data       (ma_data),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.ma_overflow   (ma_overflow),
		.slave_data    (slave_data),
		.slave_valid   (slave_valid),
		.slave_last    (slave_last),
		.slave_ready   (slave_ready)
	);

	bus_checker chk (
		.clk           (clk),
		.rst           (rst),
		.ma_frame_valid(ma_frame_valid),
		.ma_overflow   (ma_overflow),
		.slave_data    (slave_data),
		.slave_valid   (slave_valid),
		.slave_last    (slave_last),
		.slave_ready   (slave_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic load_trace();
		int                    fd;
		int                    code;
		int                    len;
		logic [63:0]           tag;
		logic [8*160-1:0]      rest;
		bus_addr_t             addr;
		logic [data_width-1:0] b;
		fd = $fopen("verif/message_trace.txt", "r");
		trace_ok = (fd != 0);
		if (!trace_ok) begin
			$display("Could not open the trace file verif/message_trace.txt");
		end
		while (trace_ok && !$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code == 1 && tag == "#") begin
				code = $fgets(rest, fd);
			end else if (code == 1) begin
				n_lines++;
				case (tag)
					"S": begin
						code = $fscanf(fd, "%h %d", addr, len);
						op_kind.push_back("S");
						op_addr.push_back(addr);
						op_len.push_back(len);
						op_first.push_back(byte_pool.size());
						for (int i = 0; i < len; i++) begin
							code = $fscanf(fd, "%h", b);
							byte_pool.push_back(b);
						end
						frame_ovf.push_back(1'b0);
					end
					"E": begin
						code = $fscanf(fd, "%d", len);
						// Reply starts with its payload count
						chk.expect_byte(len[data_width-1:0], len == 0);
						for (int i = 0; i < len; i++) begin
							code = $fscanf(fd, "%h", b);
							chk.expect_byte(b, i == len - 1);
						end
					end
					"O": begin
						if (frame_ovf.size() > 0) begin
							frame_ovf[frame_ovf.size() - 1] = 1'b1;
						end
					end
					"G": begin
						code = $fscanf(fd, "%d", len);
						op_kind.push_back("G");
						op_addr.push_back('0);
						op_len.push_back(len);
						op_first.push_back(0);
					end
					default: begin
						$display("Unknown trace entry skipped");
						code = $fgets(rest, fd);
					end
				endcase
			end
		end
		if (trace_ok) begin
			$fclose(fd);
		end
		foreach (frame_ovf[i]) begin
			chk.expect_frame(frame_ovf[i]);
		end
	endtask

	// One byte per strobe, address held until the next frame
	task automatic send_frame(input bus_addr_t addr, input int len, input int first);
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			ma_addr        = addr;
			ma_frame_valid = 1'b1;
			ma_data        = byte_pool[first + i];
			ma_data_valid  = 1'b1;
			if (i % 3 == 2 && i != len - 1) begin
				@(negedge clk);
				ma_data_valid = 1'b0;
			end
		end
		@(negedge clk);
		ma_data_valid  = 1'b0;
		ma_frame_valid = 1'b0;
	endtask

	initial begin
		seed        = 32'h32965d78;
		slave_ready = 1'b0;
		forever begin
			@(negedge clk);
			// Roughly one cycle in four stalls the slave output
			slave_ready = ($random(seed) & 3) != 0;
		end
	end

	initial begin
		wait (trace_ready);
		repeat (200 * n_lines) @(posedge clk);
		$display("Timeout: replies still missing after %0d cycles", 200 * n_lines);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst            = 1'b1;
		ma_addr        = '0;
		ma_data        = '0;
		ma_data_valid  = 1'b0;
		ma_frame_valid = 1'b0;
		load_trace();
		if (!trace_ok) begin
			$display("TESTS FAILED");
			$finish;
		end else begin
			trace_ready = 1'b1;
			repeat (10) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			for (int i = 0; i < op_kind.size(); i++) begin
				if (op_kind[i] == "S") begin
					send_frame(op_addr[i], op_len[i], op_first[i]);
				end else begin
					repeat (op_len[i]) @(negedge clk);
				end
			end
			while (!chk.all_seen()) begin
				@(posedge clk);
			end
			// Quiet period to catch stray replies
			repeat (50) @(posedge clk);
			chk.report();
			if (chk.n_errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verif/message_trace.txt */
# S addr(hex) len(dec) bytes(hex) sends a frame, E len(dec) bytes(hex) is the expected reply
# O marks the previous frame as overflowing, G cycles(dec) is an idle gap
S 10 4 a1 b2 c3 d4
E 4 a1 b2 c3 d4
G 20
S 20 5 01 02 03 04 05
E 5 01 02 03 04 05
G 20
S 30 3 de ad 99
G 20
S 10 3 11 22 33
S 20 6 41 42 43 44 45 46
E 3 11 22 33
E 6 41 42 43 44 45 46
G 30
S 10 8 80 81 82 83 84 85 86 87
E 8 80 81 82 83 84 85 86 87
G 30
S 20 16 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
E 16 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
G 40
S 10 10 90 91 92 93 94 95 96 97 98 99
O
S 10 2 5a a5
E 2 5a a5
G 20
S 20 1 ff
E 1 ff

/* sources.f */
design/bus_pkg.sv
design/msg_pkg.sv
design/message_fifo.sv
design/bus_interface.sv
design/frame_echo.sv
design/slave_arbiter.sv
design/message_bus_top.sv
verif/bus_checker.sv
verif/tb_message_bus.sv

/* Bender.yml */
package:
  name: message_bus

sources:
  - design/bus_pkg.sv
  - design/msg_pkg.sv
  - design/message_fifo.sv
  - design/bus_interface.sv
  - design/frame_echo.sv
  - design/slave_arbiter.sv
  - design/message_bus_top.sv
  - target: test
    files:
      - verif/bus_checker.sv
      - verif/tb_message_bus.sv
